// File: tileLineDma.f
+incdir+common
common/tileLineDma_pkg.sv
hdl/mapTable.sv
chipFetch/chipRam.sv
chipFetch/lineFetcher.sv
hdl/tileLineDma.sv
dv/tileLineDma_sva.sv
dv/tileLineDma_tb.sv

// File: Bender.yml
package:
  name: tileLineDma

sources:
  - include_dirs:
      - common
    files:
      - common/tileLineDma_pkg.sv
      - hdl/mapTable.sv
      - chipFetch/chipRam.sv
      - chipFetch/lineFetcher.sv
      - hdl/tileLineDma.sv

  - target: test
    include_dirs:
      - common
    files:
      - dv/tileLineDma_sva.sv
      - dv/tileLineDma_tb.sv

// File: dv/tileLineDma_tb.sv
//--------------------------------------------------------------------------
// testbench of the tile-map scanline fetcher
// loads random map and chip data, requests scanlines and checks each
// pixel against shadow copies of both memories
// a downstream model counts held pixels and returns credits
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "tileLineDma_defines.svh"

module tileLineDma_tb
	import tileLineDma_pkg::*;
();

	localparam int mapDepth  = `TLD_ROWS * `TLD_COLS;
	localparam int chipDepth = `TLD_CHIP_NUM * `TLD_CHIP_SIZE * `TLD_CHIP_SIZE;
	localparam int linePix   = `TLD_LINE_PIX;
	localparam int waitLimit = 200;

	logic      iCLK;
	logic      rstN;
	logic      mapWe;
	mapAddr_t  mapWa;
	chipId_t   mapWd;
	logic      chipWe;
	chipAddr_t chipWa;
	pixel_t    chipWd;
	logic      lineReq;
	lineNum_t  lineNum;
	logic      lineReady;
	logic      creditReturn = 1'b0;
	logic      pixValid;
	pixel_t    pixData;
	logic      pixLast;

	// shadow copies of what the host wrote
	chipId_t     mapShadow [0:mapDepth-1];
	pixel_t      chipShadow [0:chipDepth-1];
	logic [15:0] lfsrState = 16'd23766;
	// random credit delays when set
	bit          throttle = 1'b0;
	int          outstanding = 0;
	int          retDelay = 0;

	tileLineDma dut
	(
		.iCLK         (iCLK),
		.rstN         (rstN),
		.mapWe        (mapWe),
		.mapWa        (mapWa),
		.mapWd        (mapWd),
		.chipWe       (chipWe),
		.chipWa       (chipWa),
		.chipWd       (chipWd),
		.lineReq      (lineReq),
		.lineNum      (lineNum),
		.lineReady    (lineReady),
		.creditReturn (creditReturn),
		.pixValid     (pixValid),
		.pixData      (pixData),
		.pixLast      (pixLast)
	);

	// 4 ns period
	initial
	begin
		iCLK = 1'b0;
		forever #2 iCLK = ~iCLK;
	end

	task automatic failAndStop(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1, Galois form
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		return s >> 1;
	endfunction

	// one lfsr step per bit taken
	function automatic int randBits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			v = (v << 1) | lfsrState[0];
			lfsrState = lfsrStep(lfsrState);
		end
		return v;
	endfunction

	// chip from map[y/8][x/8], line y%8, pixel x%8
	function automatic pixel_t expPix(input int y, input int x);
		int id;
		id = mapShadow[(y / `TLD_CHIP_SIZE) * `TLD_COLS + x / `TLD_CHIP_SIZE];
		return chipShadow[(id * `TLD_CHIP_SIZE + y % `TLD_CHIP_SIZE) * `TLD_CHIP_SIZE
			+ x % `TLD_CHIP_SIZE];
	endfunction

	//----------------------------------------------------------------------
	// downstream model
	//----------------------------------------------------------------------
	// one credit back per received pixel, after an optional delay
	always @(posedge iCLK)
	begin
		if (!rstN)
		begin
			creditReturn <= 1'b0;
			outstanding = 0;
			retDelay = 0;
		end
		else
		begin
			creditReturn <= 1'b0;
			if (pixValid)
				outstanding = outstanding + 1;
			assert (outstanding <= `TLD_CREDIT_MAX)
			else failAndStop($sformatf("FAIL %0t ns: %0d pixels held without credit",
				$time, outstanding));
			if (outstanding > 0 && retDelay == 0)
			begin
				creditReturn <= 1'b1;
				outstanding = outstanding - 1;
				retDelay = throttle ? randBits(3) : 0;
			end
			else if (retDelay > 0)
				retDelay = retDelay - 1;
		end
	end

	//----------------------------------------------------------------------
	// host and line helpers
	//----------------------------------------------------------------------
	task automatic loadMemories();
		for (int a = 0; a < mapDepth; a++)
		begin
			@(posedge iCLK);
			mapShadow[a] = chipId_t'(randBits(3));
			mapWe <= 1'b1;
			mapWa <= mapAddr_t'(a);
			mapWd <= mapShadow[a];
		end
		for (int a = 0; a < chipDepth; a++)
		begin
			@(posedge iCLK);
			chipShadow[a] = pixel_t'(randBits(16));
			mapWe  <= 1'b0;
			chipWe <= 1'b1;
			chipWa <= chipAddr_t'(a);
			chipWd <= chipShadow[a];
		end
		@(posedge iCLK);
		chipWe <= 1'b0;
	endtask

	// request line n, check all pixels, then check the fetcher goes quiet
	// busyAt >= 0 sends a second request once that many pixels arrived
	task automatic runLine(input lineNum_t n, input bit slow, input int busyAt);
		int idx;
		int waitCnt;
		bit busySent;
		throttle = slow;
		busySent = 1'b0;
		@(posedge iCLK);
		lineReq <= 1'b1;
		lineNum <= n;
		waitCnt = 0;
		@(posedge iCLK);
		while (!lineReady)
		begin
			waitCnt++;
			if (waitCnt > waitLimit)
				failAndStop("timed out waiting for the line request to be accepted");
			@(posedge iCLK);
		end
		lineReq <= 1'b0;
		idx = 0;
		waitCnt = 0;
		while (idx < linePix)
		begin
			@(posedge iCLK);
			lineReq <= 1'b0;
			waitCnt++;
			if (waitCnt > waitLimit)
				failAndStop($sformatf("timed out waiting for pixel %0d of line %0d", idx, n));
			if (pixValid)
			begin
				assert (pixData === expPix(n, idx))
				else failAndStop($sformatf("FAIL %0t ns: line %0d pixel %0d got %h expected %h",
					$time, n, idx, pixData, expPix(n, idx)));
				assert (pixLast === (idx == linePix - 1))
				else failAndStop($sformatf("FAIL %0t ns: pixLast %b on pixel %0d",
					$time, pixLast, idx));
				idx++;
				waitCnt = 0;
			end
			// busy request with another line number
			if (busyAt >= 0 && !busySent && idx >= busyAt)
			begin
				lineReq <= 1'b1;
				lineNum <= n ^ lineNum_t'(6'h15);
				busySent = 1'b1;
			end
		end
		waitCnt = 0;
		while (!lineReady || outstanding != 0)
		begin
			@(posedge iCLK);
			waitCnt++;
			if (waitCnt > waitLimit)
				failAndStop("timed out waiting for ready and all credits after the line");
		end
		// no stray pixels and no second line
		repeat (16)
		begin
			@(posedge iCLK);
			assert (!pixValid && lineReady)
			else failAndStop($sformatf("FAIL %0t ns: activity after line %0d ended",
				$time, n));
		end
	endtask

	//----------------------------------------------------------------------
	// directed tests
	//----------------------------------------------------------------------
	task automatic testAfterReset();
		@(posedge iCLK);
		assert (lineReady === 1'b1 && pixValid === 1'b0)
		else failAndStop($sformatf("FAIL %0t ns: ready %b valid %b after reset",
			$time, lineReady, pixValid));
	endtask

	task automatic testFullLine();
		loadMemories();
		runLine(lineNum_t'(13), 1'b0, -1);
	endtask

	task automatic testThrottled();
		runLine(lineNum_t'(0), 1'b1, -1);
		runLine(lineNum_t'(63), 1'b1, -1);
	endtask

	// bump four ids of row 2, then fetch a line of that row
	task automatic testMapRewrite();
		int cols [4];
		int a;
		cols = '{0, 5, 9, 15};
		foreach (cols[i])
		begin
			@(posedge iCLK);
			a = 2 * `TLD_COLS + cols[i];
			mapShadow[a] = mapShadow[a] + 1'b1;
			mapWe <= 1'b1;
			mapWa <= mapAddr_t'(a);
			mapWd <= mapShadow[a];
		end
		@(posedge iCLK);
		mapWe <= 1'b0;
		runLine(lineNum_t'(17), 1'b0, -1);
	endtask

	task automatic testBusyRequest();
		runLine(lineNum_t'(40), 1'b0, 50);
	endtask

	initial
	begin
		rstN    = 1'b0;
		mapWe   = 1'b0;
		mapWa   = '0;
		mapWd   = '0;
		chipWe  = 1'b0;
		chipWa  = '0;
		chipWd  = '0;
		lineReq = 1'b0;
		lineNum = '0;
		repeat (3) @(posedge iCLK);
		rstN <= 1'b1;
		testAfterReset();
		testFullLine();
		testThrottled();
		testMapRewrite();
		testBusyRequest();
		@(posedge iCLK);
		if (dut.uFetch.uSva.failCount == 0)
		begin
			$display("Simulation PASSED");
			$finish;
		end
		else
		begin
			$display("Simulation FAILED");
			$fatal(1, "fetcher rule assertions failed");
		end
	end

endmodule

`default_nettype wire

// File: dv/tileLineDma_sva.sv
//--------------------------------------------------------------------------
// rule checks on the line fetcher, bound into lineFetcher
// credit ceiling, last only with valid on the final pixel,
// ready low through a whole line
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "tileLineDma_defines.svh"

module lineFetcherSva
	import tileLineDma_pkg::*;
(
	input wire logic    iCLK,
	input wire logic    rstN,
	input wire logic    lineReq,
	input wire logic    lineReady,
	input wire credit_t credit,
	input wire logic    pixValid,
	input wire logic    pixLast
);

	// index of the final pixel of a line
	localparam int LAST_IDX = `TLD_LINE_PIX - 1;

	// line in progress, acceptance through the last pixel
	logic busy;
	// valid pixels seen since acceptance
	logic [$clog2(`TLD_LINE_PIX)-1:0] pixSeen;
	int   failCount = 0;

	always_ff @(posedge iCLK or negedge rstN)
	begin
		if (!rstN)
			busy <= 1'b0;
		else if (lineReq && lineReady)
			busy <= 1'b1;
		else if (pixLast)
			busy <= 1'b0;
	end

	always_ff @(posedge iCLK or negedge rstN)
	begin
		if (!rstN)
			pixSeen <= '0;
		else if (lineReq && lineReady)
			pixSeen <= '0;
		else if (pixValid)
			pixSeen <= pixSeen + 1'b1;
	end

	creditCeiling: assert property (@(posedge iCLK) disable iff (!rstN)
		credit <= credit_t'(`TLD_CREDIT_MAX))
	else
	begin
		$error("credit count above maximum");
		failCount++;
	end

	// last marks the final pixel and only that one
	lastWithValid: assert property (@(posedge iCLK) disable iff (!rstN)
		pixLast |-> pixValid && (pixSeen == LAST_IDX))
	else
	begin
		$error("pixLast without pixValid or not on the final pixel");
		failCount++;
	end

	// ready stays low while a line is active
	readyLowInLine: assert property (@(posedge iCLK) disable iff (!rstN)
		busy |-> !lineReady)
	else
	begin
		$error("lineReady high during an active line");
		failCount++;
	end

endmodule

bind lineFetcher lineFetcherSva uSva
(
	.iCLK      (iCLK),
	.rstN      (rstN),
	.lineReq   (lineReq),
	.lineReady (lineReady),
	.credit    (credit),
	.pixValid  (pixValid),
	.pixLast   (pixLast)
);

`default_nettype wire

// File: hdl/tileLineDma.sv
//--------------------------------------------------------------------------
// tile-map scanline fetcher, top level
// host loads map table and chip store, then requests one line at a time
// pixels stream out under credit flow control from the line buffer
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tileLineDma
	import tileLineDma_pkg::*;
(
	input  wire logic      iCLK,
	input  wire logic      rstN,
	// host load of the map table
	input  wire logic      mapWe,
	input  wire mapAddr_t  mapWa,
	input  wire chipId_t   mapWd,
	// host load of the chip store
	input  wire logic      chipWe,
	input  wire chipAddr_t chipWa,
	input  wire pixel_t    chipWd,
	// line request
	input  wire logic      lineReq,
	input  wire lineNum_t  lineNum,
	output logic           lineReady,
	// credit pulse from downstream
	input  wire logic      creditReturn,
	// pixel stream
	output logic           pixValid,
	output pixel_t         pixData,
	output logic           pixLast
);

	//----------------------------------------------------------------------
	// fetcher to memory buses
	//----------------------------------------------------------------------
	mapAddr_t  mapRa;
	chipId_t   mapRd;
	chipAddr_t chipRa;
	pixel_t    chipRd;

	// tile grid
	mapTable uMap
	(
		.iCLK (iCLK),
		.we   (mapWe),
		.wa   (mapWa),
		.wd   (mapWd),
		.ra   (mapRa),
		.rd   (mapRd)
	);

	// chip pixels
	chipRam uChip
	(
		.iCLK (iCLK),
		.we   (chipWe),
		.wa   (chipWa),
		.wd   (chipWd),
		.ra   (chipRa),
		.rd   (chipRd)
	);

	// sequencer, credits and output stage
	lineFetcher uFetch
	(
		.iCLK         (iCLK),
		.rstN         (rstN),
		.lineReq      (lineReq),
		.lineNum      (lineNum),
		.lineReady    (lineReady),
		.creditReturn (creditReturn),
		.mapRa        (mapRa),
		.mapRd        (mapRd),
		.chipRa       (chipRa),
		.chipRd       (chipRd),
		.pixValid     (pixValid),
		.pixData      (pixData),
		.pixLast      (pixLast)
	);

endmodule

`default_nettype wire

// File: chipFetch/lineFetcher.sv
//--------------------------------------------------------------------------
// scanline sequencer of the tile fetcher
// takes a line request, walks the 16 tile columns, reads each chip id,
// then launches the eight pixel reads of that tile while credits last
// pixels leave one cycle after launch with a valid and a last flag
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "tileLineDma_defines.svh"

module lineFetcher
	import tileLineDma_pkg::*;
(
	input  wire logic      iCLK,
	input  wire logic      rstN,
	// line request
	input  wire logic      lineReq,
	input  wire lineNum_t  lineNum,
	output logic           lineReady,
	// credit pulse from the line buffer
	input  wire logic      creditReturn,
	// map table read
	output mapAddr_t       mapRa,
	input  wire chipId_t   mapRd,
	// chip store read
	output chipAddr_t      chipRa,
	input  wire pixel_t    chipRd,
	// pixel stream
	output logic           pixValid,
	output pixel_t         pixData,
	output logic           pixLast
);

	//----------------------------------------------------------------------
	// field widths
	//----------------------------------------------------------------------
	// line in chip and pixel in chip share this width
	localparam int SUB_W = $clog2(`TLD_CHIP_SIZE);
	// tile column index
	localparam int COL_W = $clog2(`TLD_COLS);
	// width of the full line number
	localparam int LINE_W = $bits(lineNum_t);

	fetchState_t       state;
	// line under fetch, held for the whole line
	lineNum_t          lineR;
	// current tile column
	logic [COL_W-1:0]  colCnt;
	// pixel inside the current tile
	logic [SUB_W-1:0]  pixCnt;
	// credits left
	credit_t           credit;

	logic              accept;
	logic              launch;
	logic              lastPixOfTile;
	logic              lastTile;
	logic              lastLaunch;

	//----------------------------------------------------------------------
	// handshake and launch decode
	//----------------------------------------------------------------------
	// ready only while idle, drops the cycle after acceptance
	assign lineReady = (state == IDLE);
	assign accept    = lineReady && lineReq;

	// one pixel read per cycle in PIXEL, gated by credit
	assign launch        = (state == PIXEL) && (credit != '0);
	assign lastPixOfTile = (pixCnt == SUB_W'(`TLD_CHIP_SIZE - 1));
	assign lastTile      = (colCnt == COL_W'(`TLD_COLS - 1));
	// 128th pixel of the line
	assign lastLaunch    = launch && lastPixOfTile && lastTile;

	//----------------------------------------------------------------------
	// address forming
	//----------------------------------------------------------------------
	// map row from the upper line bits, column from the walker
	assign mapRa = {lineR[LINE_W-1:SUB_W], colCnt};

	// mapRa is steady through a tile, so mapRd holds the chip id
	// of the current column from the first PIXEL cycle on
	assign chipRa = {mapRd, lineR[SUB_W-1:0], pixCnt};

	// line number latch, payload only
	always_ff @(posedge iCLK)
	begin
		if (accept)
		begin
			lineR <= lineNum;
		end
	end

	//----------------------------------------------------------------------
	// sequencer
	//----------------------------------------------------------------------
	always_ff @(posedge iCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			state  <= IDLE;
			colCnt <= '0;
			pixCnt <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (accept)
					begin
						colCnt <= '0;
						pixCnt <= '0;
						state  <= MAPRD;
					end
				end
				// map address goes out this cycle
				MAPRD:
				begin
					state <= PIXEL;
				end
				// no credit, hold everything
				PIXEL:
				begin
					if (launch)
					begin
						pixCnt <= pixCnt + 1'b1;
						if (lastPixOfTile)
						begin
							colCnt <= colCnt + 1'b1;
							if (lastTile)
							begin
								state <= DRAIN;
							end
							else
							begin
								state <= MAPRD;
							end
						end
					end
				end
				// wait for the final pixel to be presented
				DRAIN:
				begin
					if (pixLast)
					begin
						state <= IDLE;
					end
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	//----------------------------------------------------------------------
	// credit counter
	//----------------------------------------------------------------------
	// launch and return in one cycle cancel out
	always_ff @(posedge iCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			credit <= credit_t'(`TLD_CREDIT_MAX);
		end
		else
		begin
			case ({launch, creditReturn})
				2'b10:
				begin
					credit <= credit - 1'b1;
				end
				2'b01:
				begin
					credit <= credit + 1'b1;
				end
				default:
				begin
					credit <= credit;
				end
			endcase
		end
	end

	//----------------------------------------------------------------------
	// output stage
	//----------------------------------------------------------------------
	// flags delayed by one to match the chip store read
	always_ff @(posedge iCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			pixValid <= 1'b0;
			pixLast  <= 1'b0;
		end
		else
		begin
			pixValid <= launch;
			pixLast  <= lastLaunch;
		end
	end

	// data straight from the ram output register
	assign pixData = chipRd;

endmodule

`default_nettype wire

// File: chipFetch/chipRam.sv
//--------------------------------------------------------------------------
// chip store, pixels of every chip
// 8 chips of 8 by 8 words, written by the host, read by the fetcher
// address packs chip id, line in chip and pixel in chip
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "tileLineDma_defines.svh"

module chipRam
	import tileLineDma_pkg::*;
(
	input  wire logic      iCLK,
	// host write port
	input  wire logic      we,
	input  wire chipAddr_t wa,
	input  wire pixel_t    wd,
	// fetcher read port
	input  wire chipAddr_t ra,
	output pixel_t         rd
);

	//----------------------------------------------------------------------
	// storage
	//----------------------------------------------------------------------
	// 512 words with the default sizes
	localparam int DEPTH = `TLD_CHIP_NUM * `TLD_CHIP_SIZE * `TLD_CHIP_SIZE;

	// block ram, one word per pixel
	pixel_t mem [0:DEPTH-1];

	//----------------------------------------------------------------------
	// write and read
	//----------------------------------------------------------------------
	// host load, only between lines
	always_ff @(posedge iCLK)
	begin
		if (we)
		begin
			mem[wa] <= wd;
		end
	end

	// registered read, the only stage of the pixel pipeline
	// fetcher lines its valid flag up with this
	always_ff @(posedge iCLK)
	begin
		rd <= mem[ra];
	end

endmodule

`default_nettype wire

// File: hdl/mapTable.sv
//--------------------------------------------------------------------------
// map table, one chip id per tile position
// host writes the grid before a line, the fetcher reads it per column
// registered read, data one cycle after the address
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "tileLineDma_defines.svh"

module mapTable
	import tileLineDma_pkg::*;
(
	input  wire logic     iCLK,
	// host write port
	input  wire logic     we,
	input  wire mapAddr_t wa,
	input  wire chipId_t  wd,
	// fetcher read port
	input  wire mapAddr_t ra,
	output chipId_t       rd
);

	//----------------------------------------------------------------------
	// storage
	//----------------------------------------------------------------------
	// rows times columns, 128 entries
	localparam int DEPTH = `TLD_ROWS * `TLD_COLS;

	// block ram, contents come only from the host
	chipId_t mem [0:DEPTH-1];

	//----------------------------------------------------------------------
	// write and read
	//----------------------------------------------------------------------
	// synchronous write
	always_ff @(posedge iCLK)
	begin
		if (we)
		begin
			mem[wa] <= wd;
		end
	end

	// registered read
	// old data on a same-address collision, new data one cycle later
	always_ff @(posedge iCLK)
	begin
		rd <= mem[ra];
	end

endmodule

`default_nettype wire

// File: common/tileLineDma_pkg.sv
//--------------------------------------------------------------------------
// shared types of the scanline fetcher
// widths follow the size macros so address fields pack by concatenation
// pulled in by a wildcard import in each module header
//--------------------------------------------------------------------------
`default_nettype none

`include "tileLineDma_defines.svh"

package tileLineDma_pkg;

	// chip id, one entry of the map table
	typedef logic [$clog2(`TLD_CHIP_NUM)-1:0] chipId_t;

	// one pixel word
	typedef logic [`TLD_PIX_W-1:0] pixel_t;

	// map address, row in the upper bits, column in the lower bits
	typedef logic [$clog2(`TLD_ROWS * `TLD_COLS)-1:0] mapAddr_t;

	// chip store address
	// chip id, then line in chip, then pixel in chip
	typedef logic [$clog2(`TLD_CHIP_NUM * `TLD_CHIP_SIZE * `TLD_CHIP_SIZE)-1:0] chipAddr_t;

	// scanline number, 0 to 63
	typedef logic [$clog2(`TLD_ROWS * `TLD_CHIP_SIZE)-1:0] lineNum_t;

	// credit count, 0 to max inclusive
	typedef logic [$clog2(`TLD_CREDIT_MAX + 1)-1:0] credit_t;

	// fetcher states
	// IDLE   waiting for a line request
	// MAPRD  map address out for the current column
	// PIXEL  pixel launches of one tile
	// DRAIN  last pixel on its way out
	typedef enum logic [1:0]
	{
		IDLE,
		MAPRD,
		PIXEL,
		DRAIN
	} fetchState_t;

endpackage

`default_nettype wire

// File: common/tileLineDma_defines.svh
//--------------------------------------------------------------------------
// size macros for the tile-map scanline fetcher
// included by the package and by any block that needs raw sizes
// map geometry, chip geometry, pixel width and credit depth live here
//--------------------------------------------------------------------------
`ifndef TLD_DEFINES_SVH
`define TLD_DEFINES_SVH

//--------------------------------------------------------------------------
// map geometry
//--------------------------------------------------------------------------
// tile columns per map row
`define TLD_COLS 16
// tile rows in the map
`define TLD_ROWS 8

//--------------------------------------------------------------------------
// chip geometry
//--------------------------------------------------------------------------
// chip edge, square chips
`define TLD_CHIP_SIZE 8
// chips held in the chip store
`define TLD_CHIP_NUM 8
// pixel color width, rgb565 style word
`define TLD_PIX_W 16

//--------------------------------------------------------------------------
// stream
//--------------------------------------------------------------------------
// credits at reset, also the ceiling of the counter
`define TLD_CREDIT_MAX 4
// pixels in one scanline, 128 with the sizes above
`define TLD_LINE_PIX (`TLD_COLS * `TLD_CHIP_SIZE)

`endif
